/* dpc_pkg.sv */
/*
 * dpc package
 * geometry and table sizes, pixel and coordinate types, and the
 * control state encoding shared by the defective-pixel stage
 */

package dpc_pkg;

  // ===================================================================
  // widths and table size
  // ===================================================================

  // 14-bit monochrome sensor data
  localparam int pix_w = 14;

  // enough for 640 x 512 frames
  localparam int coord_w = 10;

  localparam int max_bp = 16;
  localparam int bp_idx_w = 4;

  // per-frame detection count, saturates
  localparam int cnt_w = 9;

  // ===================================================================
  // types
  // ===================================================================

  typedef logic [pix_w-1:0] pixel_t;
  typedef logic [coord_w-1:0] coord_t;
  typedef logic [bp_idx_w-1:0] bp_idx_t;
  typedef logic [cnt_w-1:0] bp_cnt_t;

  // frame sequencing
  typedef enum logic [1:0] {
    idle     = 2'd0,
    wait_sof = 2'd1,
    active   = 2'd2,
    done     = 2'd3
  } dpc_state_e;

endpackage

/* pix_stream_if.sv */
/*
 * pixel stream interface
 * axi4-stream style beat: tuser marks frame start, tlast marks line end
 */

interface pix_stream_if;

  logic            tvalid;
  dpc_pkg::pixel_t tdata;
  logic            tuser;
  logic            tlast;
  logic            tready;

  modport src (output tvalid, output tdata, output tuser, output tlast,
               input tready);

  modport snk (input tvalid, input tdata, input tuser, input tlast,
               output tready);

  // observers only, never drive
  modport mon (input tvalid, input tdata, input tuser, input tlast,
               input tready);

endinterface

/* dpc_frame_counter.sv */
/*
 * frame counter
 * tracks column and row of the current beat on the pixel stream
 * tuser restarts at (0, 0), tlast moves to the next row
 */

module dpc_frame_counter (
  input  logic           axis_aclk,
  input  logic           axis_aresetn,
  pix_stream_if.mon      strm,
  output dpc_pkg::coord_t pix_x,
  output dpc_pkg::coord_t pix_y
);

  import dpc_pkg::*;

  coord_t nxt_x;
  coord_t nxt_y;
  logic   beat;

  assign beat = strm.tvalid && strm.tready;

  // frame start always reports the origin
  assign pix_x = strm.tuser ? '0 : nxt_x;
  assign pix_y = strm.tuser ? '0 : nxt_y;

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
    begin
      nxt_x <= '0;
      nxt_y <= '0;
    end
    else if (beat)
    begin
      if (strm.tlast)
      begin
        nxt_x <= '0;
        nxt_y <= pix_y + coord_t'(1);
      end
      else
      begin
        nxt_x <= pix_x + coord_t'(1);
        nxt_y <= pix_y;
      end
    end
  end

  // a frame start that also ends a line only fits a fresh row
  a_sof_row: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    (beat && strm.tuser && strm.tlast) |-> (nxt_y == '0));

endmodule

/* dpc_ctrl_fsm.sv */
/*
 * control state machine
 * arms on enable, starts a frame on tuser, ends it on the tlast of the
 * last row and gives a one-cycle frame done
 */

module dpc_ctrl_fsm (
  input  logic            axis_aclk,
  input  logic            axis_aresetn,
  pix_stream_if.mon       strm,
  input  logic            enable,
  input  dpc_pkg::coord_t frame_height,
  input  dpc_pkg::coord_t pix_y,
  output logic            frame_active,
  output logic            frame_done
);

  import dpc_pkg::*;

  dpc_state_e state_q;
  dpc_state_e state_d;
  coord_t     last_row;
  logic       beat;
  logic       frame_end;

  assign beat      = strm.tvalid && strm.tready;
  assign last_row  = frame_height - coord_t'(1);
  assign frame_end = beat && strm.tlast && (pix_y == last_row);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      idle:     if (enable) state_d = wait_sof;
      // the sof beat itself already belongs to the frame
      wait_sof: if (beat && strm.tuser) state_d = frame_end ? done : active;
      active:   if (frame_end) state_d = done;
      done:     state_d = enable ? wait_sof : idle;
      default:  state_d = idle;
    endcase
  end

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
      state_q <= idle;
    else
      state_q <= state_d;
  end

  assign frame_active = (state_q == active) ||
                        ((state_q == wait_sof) && beat && strm.tuser);
  assign frame_done   = (state_q == done);

  a_done_pulse: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    frame_done |=> !frame_done);

endmodule

/* dpc_bp_table.sv */
/*
 * bad-pixel table
 * max_bp coordinate pairs loaded by a write strobe
 * all active entries are compared with the current position at once
 */

module dpc_bp_table (
  input  logic                      axis_aclk,
  input  logic                      axis_aresetn,
  input  logic                      bp_wr_en,
  input  dpc_pkg::bp_idx_t          bp_wr_addr,
  input  dpc_pkg::coord_t           bp_wr_x,
  input  dpc_pkg::coord_t           bp_wr_y,
  input  logic [dpc_pkg::bp_idx_w:0] bp_num,
  input  dpc_pkg::coord_t           pix_x,
  input  dpc_pkg::coord_t           pix_y,
  output logic                      bp_hit
);

  import dpc_pkg::*;

  coord_t            tab_x [max_bp];
  coord_t            tab_y [max_bp];
  logic [max_bp-1:0] tab_vld;

  // entry written since reset
  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
      tab_vld <= '0;
    else if (bp_wr_en)
      tab_vld[bp_wr_addr] <= 1'b1;
  end

  always_ff @(posedge axis_aclk)
  begin
    if (bp_wr_en)
    begin
      tab_x[bp_wr_addr] <= bp_wr_x;
      tab_y[bp_wr_addr] <= bp_wr_y;
    end
  end

  // only the first bp_num entries take part
  always_comb
  begin
    bp_hit = 1'b0;
    for (int i = 0; i < max_bp; i++)
    begin
      if (tab_vld[i] && (i < int'(bp_num)) && (tab_x[i] == pix_x) && (tab_y[i] == pix_y))
        bp_hit = 1'b1;
    end
  end

  a_bp_num: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    bp_num <= (bp_idx_w + 1)'(max_bp));

endmodule

/* dpc_detector.sv */
/*
 * threshold detector
 * compares each pixel with a running reference of its row and reports
 * unlisted pixels that stray more than k_threshold, counting per frame
 */

module dpc_detector (
  input  logic             axis_aclk,
  input  logic             axis_aresetn,
  pix_stream_if.mon        strm,
  input  logic             frame_active,
  input  logic             bp_hit,
  input  dpc_pkg::coord_t  pix_x,
  input  dpc_pkg::coord_t  pix_y,
  input  dpc_pkg::pixel_t  k_threshold,
  input  logic             frame_done,
  output logic             auto_bp_valid,
  output dpc_pkg::coord_t  auto_bp_x,
  output dpc_pkg::coord_t  auto_bp_y,
  output dpc_pkg::bp_cnt_t detected_bp_count
);

  import dpc_pkg::*;

  pixel_t  ref_pix;
  pixel_t  abs_diff;
  bp_cnt_t work_cnt;
  bp_cnt_t frame_cnt;
  logic    beat;
  logic    flag;

  assign beat     = strm.tvalid && strm.tready;
  assign abs_diff = (strm.tdata > ref_pix) ? strm.tdata - ref_pix : ref_pix - strm.tdata;
  assign flag     = beat && frame_active && !bp_hit && (pix_x != '0) &&
                    (abs_diff > k_threshold);

  // reference holds across a flagged pixel
  always_ff @(posedge axis_aclk)
  begin
    if (beat && !flag)
      ref_pix <= strm.tdata;
    if (flag)
    begin
      auto_bp_x <= pix_x;
      auto_bp_y <= pix_y;
    end
  end

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
    begin
      auto_bp_valid <= 1'b0;
      work_cnt      <= '0;
      frame_cnt     <= '0;
    end
    else
    begin
      auto_bp_valid <= flag;
      if (beat && strm.tuser)
        work_cnt <= '0;
      else if (flag && (work_cnt != '1))
        work_cnt <= work_cnt + bp_cnt_t'(1);
      if (frame_done)
        frame_cnt <= work_cnt;
    end
  end

  // count is visible already in the done cycle
  assign detected_bp_count = frame_done ? work_cnt : frame_cnt;

endmodule

/* dpc_corrector.sv */
/*
 * corrector output stage
 * single output register with skid-free handshake
 * listed pixels in a processed frame take the previous output pixel
 */

module dpc_corrector (
  input  logic            axis_aclk,
  input  logic            axis_aresetn,
  pix_stream_if.snk       strm,
  input  logic            frame_active,
  input  logic            bp_hit,
  input  dpc_pkg::coord_t pix_x,
  output logic            m_axis_tvalid,
  input  logic            m_axis_tready,
  output dpc_pkg::pixel_t m_axis_tdata,
  output logic            m_axis_tuser,
  output logic            m_axis_tlast
);

  import dpc_pkg::*;

  pixel_t data_d;
  logic   beat;
  logic   subst;

  // register frees up when drained or empty
  assign strm.tready = m_axis_tready || !m_axis_tvalid;
  assign beat        = strm.tvalid && strm.tready;

  // output register still holds the previous pixel of the row
  assign subst  = frame_active && bp_hit && (pix_x != '0);
  assign data_d = subst ? m_axis_tdata : strm.tdata;

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
      m_axis_tvalid <= 1'b0;
    else if (beat)
      m_axis_tvalid <= 1'b1;
    else if (m_axis_tready)
      m_axis_tvalid <= 1'b0;
  end

  always_ff @(posedge axis_aclk)
  begin
    if (beat)
    begin
      m_axis_tdata <= data_d;
      m_axis_tuser <= strm.tuser;
      m_axis_tlast <= strm.tlast;
    end
  end

  a_stall_stable: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser) &&
       $stable(m_axis_tlast)));

endmodule

/* dpc_top.sv */
/*
 * defective-pixel stage, top level
 * detector reports out-of-threshold pixels, corrector patches the
 * pixels listed in the table, both share one position and frame control
 */

module dpc_top (
  input  logic                       axis_aclk,
  input  logic                       axis_aresetn,
  input  logic                       s_axis_tvalid,
  input  dpc_pkg::pixel_t            s_axis_tdata,
  input  logic                       s_axis_tuser,
  input  logic                       s_axis_tlast,
  output logic                       s_axis_tready,
  output logic                       m_axis_tvalid,
  output dpc_pkg::pixel_t            m_axis_tdata,
  output logic                       m_axis_tuser,
  output logic                       m_axis_tlast,
  input  logic                       m_axis_tready,
  input  logic                       enable,
  input  dpc_pkg::pixel_t            k_threshold,
  input  dpc_pkg::coord_t            frame_height,
  input  logic                       bp_wr_en,
  input  dpc_pkg::bp_idx_t           bp_wr_addr,
  input  dpc_pkg::coord_t            bp_wr_x,
  input  dpc_pkg::coord_t            bp_wr_y,
  input  logic [dpc_pkg::bp_idx_w:0] bp_num,
  output logic                       auto_bp_valid,
  output dpc_pkg::coord_t            auto_bp_x,
  output dpc_pkg::coord_t            auto_bp_y,
  output logic                       frame_detection_done,
  output dpc_pkg::bp_cnt_t           detected_bp_count
);

  import dpc_pkg::*;

  coord_t pix_x;
  coord_t pix_y;
  logic   frame_active;
  logic   frame_done;
  logic   bp_hit;

  pix_stream_if strm ();

  // ===================================================================
  // input stream onto the internal bus
  // ===================================================================

  assign strm.tvalid          = s_axis_tvalid;
  assign strm.tdata           = s_axis_tdata;
  assign strm.tuser           = s_axis_tuser;
  assign strm.tlast           = s_axis_tlast;
  assign s_axis_tready        = strm.tready;
  assign frame_detection_done = frame_done;

  dpc_frame_counter frame_counter_i (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .strm         (strm),
    .pix_x        (pix_x),
    .pix_y        (pix_y)
  );

  dpc_ctrl_fsm ctrl_fsm_i (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .strm         (strm),
    .enable       (enable),
    .frame_height (frame_height),
    .pix_y        (pix_y),
    .frame_active (frame_active),
    .frame_done   (frame_done)
  );

  dpc_bp_table bp_table_i (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .bp_wr_en     (bp_wr_en),
    .bp_wr_addr   (bp_wr_addr),
    .bp_wr_x      (bp_wr_x),
    .bp_wr_y      (bp_wr_y),
    .bp_num       (bp_num),
    .pix_x        (pix_x),
    .pix_y        (pix_y),
    .bp_hit       (bp_hit)
  );

  dpc_detector detector_i (
    .axis_aclk         (axis_aclk),
    .axis_aresetn      (axis_aresetn),
    .strm              (strm),
    .frame_active      (frame_active),
    .bp_hit            (bp_hit),
    .pix_x             (pix_x),
    .pix_y             (pix_y),
    .k_threshold       (k_threshold),
    .frame_done        (frame_done),
    .auto_bp_valid     (auto_bp_valid),
    .auto_bp_x         (auto_bp_x),
    .auto_bp_y         (auto_bp_y),
    .detected_bp_count (detected_bp_count)
  );

  dpc_corrector corrector_i (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .strm          (strm),
    .frame_active  (frame_active),
    .bp_hit        (bp_hit),
    .pix_x         (pix_x),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

/* tb_dpc_top.sv */
/*
 * testbench for the defective-pixel stage
 * streams 8x4 frames through dpc_top under random back-pressure, predicts
 * every output beat, report and frame status with a queue model, and
 * checks the DUT against it with concurrent assertions
 */

module tb_dpc_top;

  import dpc_pkg::*;

  localparam int n_frames = 7;
  localparam int n_beats  = n_frames * 32;

  logic                axis_aclk = 1'b0;
  logic                axis_aresetn;
  logic                s_axis_tvalid;
  pixel_t              s_axis_tdata;
  logic                s_axis_tuser;
  logic                s_axis_tlast;
  logic                s_axis_tready;
  logic                m_axis_tvalid;
  pixel_t              m_axis_tdata;
  logic                m_axis_tuser;
  logic                m_axis_tlast;
  logic                m_axis_tready = 1'b1;
  logic                enable;
  pixel_t              k_threshold;
  coord_t              frame_height;
  logic                bp_wr_en;
  bp_idx_t             bp_wr_addr;
  coord_t              bp_wr_x;
  coord_t              bp_wr_y;
  logic [bp_idx_w:0]   bp_num;
  logic                auto_bp_valid;
  coord_t              auto_bp_x;
  coord_t              auto_bp_y;
  logic                frame_detection_done;
  bp_cnt_t             detected_bp_count;

  // reference model
  dpc_state_e          m_state;
  coord_t              m_nx;
  coord_t              m_ny;
  coord_t              bx;
  coord_t              by;
  bp_cnt_t             m_cnt;
  pixel_t              ref_pix;
  pixel_t              diff;
  pixel_t              out_pix;
  pixel_t              last_out;
  coord_t              tab_x [max_bp];
  coord_t              tab_y [max_bp];
  logic [max_bp-1:0]   tab_vld;
  logic                in_beat;
  logic                act;
  logic                hit;
  logic                frame_end;
  logic                rep_pend;
  logic                done_pend;
  coord_t              pend_x;
  coord_t              pend_y;
  logic [pix_w+1:0]    exp_q [$];

  // expected values seen by the checks at the next rising edge
  logic                exp_ok;
  logic [pix_w+1:0]    exp_beat;
  logic                exp_ready;
  logic                exp_rep_valid;
  coord_t              exp_rep_x;
  coord_t              exp_rep_y;
  logic                exp_done;
  bp_cnt_t             exp_count;

  logic [pix_w+1:0]    out_beat;
  logic                rand_ready = 1'b0;
  string               test_name = "reset";
  int                  out_errs = 0;
  int                  rep_errs = 0;
  int                  frame_errs = 0;

  assign out_beat = {m_axis_tuser, m_axis_tlast, m_axis_tdata};

  always #2 axis_aclk = ~axis_aclk;

  dpc_top dpc_top_i (.*);

  always @(posedge axis_aclk)
  begin
    #1;
    m_axis_tready = rand_ready ? (($urandom % 2) != 0) : 1'b1;
  end

  function automatic logic table_hit(input coord_t x, input coord_t y);
    logic found;
    found = 1'b0;
    for (int i = 0; i < max_bp; i++)
      if (tab_vld[i] && (i < int'(bp_num)) && (tab_x[i] == x) && (tab_y[i] == y))
        found = 1'b1;
    return found;
  endfunction

  // ====================================================================
  // model evaluated at the falling edge where all inputs are settled
  // ====================================================================

  always @(negedge axis_aclk)
  begin
    if (!axis_aresetn)
    begin
      m_state       = idle;
      m_nx          = '0;
      m_ny          = '0;
      m_cnt         = '0;
      tab_vld       = '0;
      rep_pend      = 1'b0;
      done_pend     = 1'b0;
      in_beat       = 1'b0;
      exp_ok        = 1'b0;
      exp_ready     = 1'b1;
      exp_rep_valid = 1'b0;
      exp_done      = 1'b0;
      exp_count     = '0;
    end
    else
    begin
      // pulses of last cycle's beat
      exp_rep_valid = rep_pend;
      exp_rep_x     = pend_x;
      exp_rep_y     = pend_y;
      exp_done      = done_pend;
      if (done_pend)
        exp_count = m_cnt;
      rep_pend = 1'b0;

      // one pending beat at most, it sits in the output register
      exp_ready = m_axis_tready || (exp_q.size() == 0);

      if (m_axis_tvalid && m_axis_tready)
      begin
        exp_ok = (exp_q.size() != 0);
        if (exp_ok)
          exp_beat = exp_q.pop_front();
      end

      in_beat   = s_axis_tvalid && s_axis_tready;
      frame_end = 1'b0;
      act       = (m_state == active) || ((m_state == wait_sof) && in_beat && s_axis_tuser);
      if (in_beat)
      begin
        bx   = s_axis_tuser ? '0 : m_nx;
        by   = s_axis_tuser ? '0 : m_ny;
        hit  = table_hit(bx, by);
        diff = (s_axis_tdata > ref_pix) ? s_axis_tdata - ref_pix : ref_pix - s_axis_tdata;
        if (s_axis_tuser)
          m_cnt = '0;
        if ((bx != '0) && act && !hit && (diff > k_threshold))
        begin
          rep_pend = 1'b1;
          pend_x   = bx;
          pend_y   = by;
          if (m_cnt != '1)
            m_cnt = m_cnt + bp_cnt_t'(1);
        end
        else
          ref_pix = s_axis_tdata;
        out_pix  = (act && hit && (bx != '0)) ? last_out : s_axis_tdata;
        last_out = out_pix;
        exp_q.push_back({s_axis_tuser, s_axis_tlast, out_pix});
        frame_end = act && s_axis_tlast && (by == frame_height - coord_t'(1));
        m_nx = s_axis_tlast ? '0 : bx + coord_t'(1);
        m_ny = s_axis_tlast ? by + coord_t'(1) : by;
      end

      case (m_state)
        idle:     if (enable) m_state = wait_sof;
        wait_sof: if (act) m_state = frame_end ? done : active;
        active:   if (frame_end) m_state = done;
        default:  m_state = enable ? wait_sof : idle;
      endcase
      done_pend = (m_state == done);

      // a write only counts for the lookups after it
      if (bp_wr_en)
      begin
        tab_x[bp_wr_addr]   = bp_wr_x;
        tab_y[bp_wr_addr]   = bp_wr_y;
        tab_vld[bp_wr_addr] = 1'b1;
      end
    end
  end

  // ====================================================================
  // checks
  // ====================================================================

  a_ready: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    s_axis_tready == exp_ready)
  else
  begin
    out_errs++;
    $display("[ERROR] %s s_axis_tready: expected %b actual %b",
             test_name, exp_ready, $sampled(s_axis_tready));
  end

  a_out_known: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    (m_axis_tvalid && m_axis_tready) |-> exp_ok)
  else
  begin
    out_errs++;
    $display("test %s: output beat with no input beat left to match it", test_name);
  end

  a_out_beat: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    (m_axis_tvalid && m_axis_tready && exp_ok) |-> (out_beat == exp_beat))
  else
  begin
    out_errs++;
    $display("[ERROR] %s output {tuser,tlast,tdata}: expected %h actual %h",
             test_name, exp_beat, $sampled(out_beat));
  end

  a_report: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    auto_bp_valid == exp_rep_valid)
  else
  begin
    rep_errs++;
    $display("[ERROR] %s auto_bp_valid: expected %b actual %b",
             test_name, exp_rep_valid, $sampled(auto_bp_valid));
  end

  a_report_pos: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    (auto_bp_valid && exp_rep_valid) |-> ((auto_bp_x == exp_rep_x) && (auto_bp_y == exp_rep_y)))
  else
  begin
    rep_errs++;
    $display("[ERROR] %s report position: expected (%0d,%0d) actual (%0d,%0d)", test_name,
             exp_rep_x, exp_rep_y, $sampled(auto_bp_x), $sampled(auto_bp_y));
  end

  a_done: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    frame_detection_done == exp_done)
  else
  begin
    frame_errs++;
    $display("[ERROR] %s frame_detection_done: expected %b actual %b",
             test_name, exp_done, $sampled(frame_detection_done));
  end

  a_count: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    detected_bp_count == exp_count)
  else
  begin
    frame_errs++;
    $display("[ERROR] %s detected_bp_count: expected %0d actual %0d",
             test_name, exp_count, $sampled(detected_bp_count));
  end

  // ====================================================================
  // stimulus
  // ====================================================================

  task automatic send_beat(input pixel_t d, input logic u, input logic l);
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = d;
    s_axis_tuser  = u;
    s_axis_tlast  = l;
    do
      @(posedge axis_aclk);
    while (!in_beat);
    #1;
    s_axis_tvalid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge axis_aclk);
    #1;
  endtask

  task automatic write_entry(input int addr, input int x, input int y);
    bp_wr_en   = 1'b1;
    bp_wr_addr = bp_idx_t'(addr);
    bp_wr_x    = coord_t'(x);
    bp_wr_y    = coord_t'(y);
    @(posedge axis_aclk);
    #1;
    bp_wr_en = 1'b0;
  endtask

  // noisy flat frame with enable set to en_val at beat en_beat
  task automatic send_frame(input int en_beat, input logic en_val);
    pixel_t prev;
    pixel_t px;
    prev = pixel_t'(1000);
    for (int y = 0; y < 4; y++)
    begin
      for (int x = 0; x < 8; x++)
      begin
        if ((y * 8 + x) == en_beat)
          enable = en_val;
        px = pixel_t'(1000 + ($urandom % 8));
        // spikes and one step right at the threshold
        if ((x == 2) && (y == 0))
          px = prev + pixel_t'(200);
        else if ((x == 4) && (y == 1))
          px = prev + pixel_t'(51);
        else if ((x == 7) && (y == 1))
          px = prev + pixel_t'(300);
        else if ((x == 7) && (y == 3))
          px = prev + pixel_t'(50);
        send_beat(px, (x == 0) && (y == 0), x == 7);
        prev = px;
      end
    end
  endtask

  initial
  begin
    void'($urandom(73757));
    axis_aresetn  = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tuser  = 1'b0;
    s_axis_tlast  = 1'b0;
    enable        = 1'b0;
    k_threshold   = pixel_t'(50);
    frame_height  = coord_t'(4);
    bp_wr_en      = 1'b0;
    bp_wr_addr    = '0;
    bp_wr_x       = '0;
    bp_wr_y       = '0;
    bp_num        = '0;
    repeat (5) @(posedge axis_aclk);
    #1;
    axis_aresetn = 1'b1;
    @(posedge axis_aclk);
    #1;
    assert (!m_axis_tvalid && !auto_bp_valid && !frame_detection_done &&
            (detected_bp_count == '0))
    else
    begin
      frame_errs++;
      $display("control outputs are not low after reset");
    end

    test_name = "table";
    write_entry(0, 7, 1);
    write_entry(1, 0, 2);
    write_entry(2, 5, 2);
    write_entry(3, 3, 3);
    // beyond bp_num so (2,0) stays unlisted
    write_entry(4, 2, 0);
    bp_num = 5'd4;

    test_name  = "passthru";
    rand_ready = 1'b1;
    send_frame(-1, 1'b0);
    send_frame(-1, 1'b0);
    idle_cycles(4);

    test_name = "correct";
    enable = 1'b1;
    idle_cycles(2);
    send_frame(-1, 1'b1);
    idle_cycles(4);
    send_frame(-1, 1'b1);
    idle_cycles(4);
    // enable drops mid-frame but the frame still completes
    send_frame(20, 1'b0);
    idle_cycles(4);

    test_name = "mid_enable";
    send_frame(12, 1'b1);
    idle_cycles(4);
    send_frame(-1, 1'b1);

    rand_ready = 1'b0;
    idle_cycles(8);
    assert (exp_q.size() == 0)
    else
    begin
      out_errs++;
      $display("%0d accepted beats never reached the output", exp_q.size());
    end
    $display("errors: output %0d, report %0d, frame %0d", out_errs, rep_errs, frame_errs);
    if ((out_errs + rep_errs + frame_errs) == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(n_beats * 4 * 8);
    $display("watchdog expired, stream stalled in test %s", test_name);
    $display("tests failed");
    $finish;
  end

endmodule

/* sources.f */
dpc_pkg.sv
pix_stream_if.sv
dpc_frame_counter.sv
dpc_ctrl_fsm.sv
dpc_bp_table.sv
dpc_detector.sv
dpc_corrector.sv
dpc_top.sv
tb_dpc_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dpc_top -f sources.f || exit 1
out=$(./obj_dir/Vtb_dpc_top)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
